// ==== Makefile ====
# verilator build and run of the camera overlay testbench

TOP = tb_frame_overlay

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f files.f \
		--top-module $(TOP) -o $(TOP)

# pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
video_pkg.sv
frame_pkg.sv
video_timing.sv
frame_store.sv
pixel_fetch.sv
marker_overlay.sv
frame_overlay_top.sv
tb_frame_overlay.sv

// ==== frame_overlay_top.sv ====
//////////////////////////////////////////////////////////////////////
// camera overlay display path: raster, frame memory fetch and
// crosshair overlay onto the vga outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module frame_overlay_top #(
   parameter int h_active     = 1024,
   parameter int h_sync_start = 1048,
   parameter int h_sync_end   = 1184,
   parameter int h_total      = 1344,
   parameter int v_active     = 768,
   parameter int v_sync_start = 777,
   parameter int v_sync_end   = 783,
   parameter int v_total      = 806,
   parameter int win_width    = 720,
   parameter int win_height   = 460,
   parameter int marker_width = 4
) (
   input  logic                    clk,
   input  logic                    reset,
   input  frame_pkg::frame_write_t cap_write,
   input  logic                    mode_button,
   input  video_pkg::marker_pos_t  red_marker,
   input  video_pkg::marker_pos_t  green_marker,
   output video_pkg::pixel24_t     vga_pixel,
   output logic                    vga_hsync,
   output logic                    vga_vsync,
   output logic                    vga_blank
);
   import video_pkg::*;
   import frame_pkg::*;

   raster_t     raster;
   frame_req_t  mem_req;
   frame_word_t mem_rdata;
   pixel18_t    cam_pixel;

   // raster source for the whole path
   video_timing #(
      .h_active     (h_active),
      .h_sync_start (h_sync_start),
      .h_sync_end   (h_sync_end),
      .h_total      (h_total),
      .v_active     (v_active),
      .v_sync_start (v_sync_start),
      .v_sync_end   (v_sync_end),
      .v_total      (v_total)
   ) i_video_timing (
      .clk    (clk),
      .reset  (reset),
      .raster (raster)
   );

   // reads ahead and shares the memory with capture writes
   pixel_fetch #(
      .h_total    (h_total),
      .v_total    (v_total),
      .win_width  (win_width),
      .win_height (win_height)
   ) i_pixel_fetch (
      .clk       (clk),
      .reset     (reset),
      .raster    (raster),
      .cap_write (cap_write),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata),
      .cam_pixel (cam_pixel)
   );

   frame_store i_frame_store (
      .clk       (clk),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata)
   );

   // crosshairs and the output registers
   marker_overlay #(
      .win_width    (win_width),
      .win_height   (win_height),
      .marker_width (marker_width)
   ) i_marker_overlay (
      .clk          (clk),
      .reset        (reset),
      .raster       (raster),
      .cam_pixel    (cam_pixel),
      .mode_button  (mode_button),
      .red_marker   (red_marker),
      .green_marker (green_marker),
      .vga_pixel    (vga_pixel),
      .vga_hsync    (vga_hsync),
      .vga_vsync    (vga_vsync),
      .vga_blank    (vga_blank)
   );

endmodule

`default_nettype wire

// ==== frame_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// frame memory types: word layout, address, capture write and the
// request presented to the memory each cycle
//////////////////////////////////////////////////////////////////////

`default_nettype none

package frame_pkg;

   // read ahead distance, set by the two cycle memory latency
   localparam int fetch_lead = 4;

   // {line, pixel count / 2}
   typedef logic [18:0] frame_addr_t;

   // two neighbouring pixels, the even one in the upper half
   typedef struct packed {
      video_pkg::pixel18_t hi_pixel;
      video_pkg::pixel18_t lo_pixel;
   } frame_word_t;

   // pixel pair offered by the capture side
   typedef struct packed {
      logic        valid;
      frame_addr_t addr;
      frame_word_t word;
   } frame_write_t;

   // one memory access, read when we is low
   typedef struct packed {
      logic        we;
      frame_addr_t addr;
      frame_word_t word;
   } frame_req_t;

endpackage

`default_nettype wire

// ==== frame_store.sv ====
//////////////////////////////////////////////////////////////////////
// single port frame memory of 36 bit words, read data two clocks
// after the address, as on the board's zbt ram
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module frame_store (
   input  logic                   clk,
   input  frame_pkg::frame_req_t  mem_req,
   output frame_pkg::frame_word_t mem_rdata
);
   import frame_pkg::*;

   localparam int depth = 2 ** $bits(frame_addr_t);

   frame_word_t mem [0:depth-1];
   // first read stage, the array output register
   frame_word_t read_stage;

   //////////////////////////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////////////////////////

   // write lands at the edge it is presented on
   always_ff @(posedge clk) begin
      if (mem_req.we) begin
         mem[mem_req.addr] <= mem_req.word;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read pipeline
   //////////////////////////////////////////////////////////////////////

   // address sampled every cycle, so two reads are always in flight
   // a write cycle reads the old contents, which nobody uses
   always_ff @(posedge clk) begin
      read_stage <= mem[mem_req.addr];
      mem_rdata <= read_stage;
   end

endmodule

`default_nettype wire

// ==== marker_overlay.sv ====
//////////////////////////////////////////////////////////////////////
// crosshair overlay: colour mode stepping on the button, red and
// green crosshairs over the camera image, registered vga outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module marker_overlay #(
   parameter int win_width    = 720,
   parameter int win_height   = 460,
   parameter int marker_width = 4
) (
   input  logic                   clk,
   input  logic                   reset,
   input  video_pkg::raster_t     raster,
   input  video_pkg::pixel18_t    cam_pixel,
   input  logic                   mode_button,
   input  video_pkg::marker_pos_t red_marker,
   input  video_pkg::marker_pos_t green_marker,
   output video_pkg::pixel24_t    vga_pixel,
   output logic                   vga_hsync,
   output logic                   vga_vsync,
   output logic                   vga_blank
);
   import video_pkg::*;

   color_mode_t mode;
   logic        button_q;
   logic        button_rise;
   logic        red_hit;
   logic        green_hit;
   logic        show_red;
   logic        show_green;
   pixel24_t    cam_wide;
   pixel24_t    next_pixel;

   // true when the raster sits on either bar of a crosshair
   function automatic logic on_marker(input marker_pos_t m, input raster_t r);
      logic [11:0] x_end;
      logic [10:0] y_end;
      logic        vert_bar;
      logic        horiz_bar;
      // one bit wider so a marker near the edge does not wrap
      x_end = {1'b0, m.x} + 12'(marker_width);
      y_end = {1'b0, m.y} + 11'(marker_width);
      // vertical bar spans the window height
      vert_bar = (r.hcount >= m.x) && ({1'b0, r.hcount} < x_end) &&
                 (r.vcount < vcount_t'(win_height));
      // horizontal bar spans the window width
      horiz_bar = (r.vcount >= m.y) && ({1'b0, r.vcount} < y_end) &&
                  (r.hcount < hcount_t'(win_width));
      return vert_bar || horiz_bar;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // colour mode
   //////////////////////////////////////////////////////////////////////

   // one step per rising edge, holding the button does nothing more
   assign button_rise = mode_button && !button_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         button_q <= 1'b0;
         mode <= mode_green;
      end else begin
         button_q <= mode_button;
         if (button_rise) begin
            // none wraps back to green
            mode <= color_mode_t'(mode + 2'd1);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // pixel select
   //////////////////////////////////////////////////////////////////////

   assign red_hit = on_marker(red_marker, raster);
   assign green_hit = on_marker(green_marker, raster);
   assign show_green = green_hit && ((mode == mode_green) || (mode == mode_both));
   assign show_red = red_hit && ((mode == mode_red) || (mode == mode_both));

   // 6 bit colours padded to the dac width
   assign cam_wide = {cam_pixel.red, 2'b00, cam_pixel.green, 2'b00, cam_pixel.blue, 2'b00};

   // green drawn on top of red
   always_comb begin
      if (raster.blank) begin
         next_pixel = '0;
      end else if (show_green) begin
         next_pixel = green_marker_color;
      end else if (show_red) begin
         next_pixel = red_marker_color;
      end else begin
         next_pixel = cam_wide;
      end
   end

   // pixel and sync levels leave in the same clock
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_pixel <= '0;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_blank <= 1'b1;
      end else begin
         vga_pixel <= next_pixel;
         vga_hsync <= raster.hsync;
         vga_vsync <= raster.vsync;
         vga_blank <= raster.blank;
      end
   end

endmodule

`default_nettype wire

// ==== pixel_fetch.sv ====
//////////////////////////////////////////////////////////////////////
// camera pixel fetch: reads the frame memory four pixels ahead,
// gives odd cycles to capture writes and picks the pixel half
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pixel_fetch #(
   parameter int h_total    = 1344,
   parameter int v_total    = 806,
   parameter int win_width  = 720,
   parameter int win_height = 460
) (
   input  logic                    clk,
   input  logic                    reset,
   input  video_pkg::raster_t      raster,
   input  frame_pkg::frame_write_t cap_write,
   output frame_pkg::frame_req_t   mem_req,
   input  frame_pkg::frame_word_t  mem_rdata,
   output video_pkg::pixel18_t     cam_pixel
);
   import video_pkg::*;
   import frame_pkg::*;

   hcount_t     ahead_h;
   hcount_t     fetch_h;
   vcount_t     fetch_v;
   logic        line_wrap;
   frame_addr_t read_addr;
   logic        take_write;
   frame_word_t next_word;
   frame_word_t cur_word;
   logic        in_window;

   //////////////////////////////////////////////////////////////////////
   // forecast address
   //////////////////////////////////////////////////////////////////////

   // position fetch_lead pixels ahead, wrapping into the next line
   assign ahead_h = raster.hcount + hcount_t'(fetch_lead);
   assign line_wrap = (ahead_h >= hcount_t'(h_total));

   always_comb begin
      if (line_wrap) begin
         fetch_h = ahead_h - hcount_t'(h_total);
         // last line wraps back to the top of the frame
         if (raster.vcount == vcount_t'(v_total - 1)) begin
            fetch_v = '0;
         end else begin
            fetch_v = raster.vcount + 1'b1;
         end
      end else begin
         fetch_h = ahead_h;
         fetch_v = raster.vcount;
      end
   end

   // two pixels per word, so the pixel count drops its low bit
   assign read_addr = {fetch_v, fetch_h[9:1]};

   // even counts always read, odd counts carry a pending capture write
   assign take_write = raster.hcount[0] && cap_write.valid;

   always_comb begin
      mem_req.we = take_write;
      mem_req.addr = take_write ? cap_write.addr : read_addr;
      mem_req.word = cap_write.word;
   end

   //////////////////////////////////////////////////////////////////////
   // word latches
   //////////////////////////////////////////////////////////////////////

   // an even count read returns two clocks later, again on an even count
   // the odd count after it moves the word into place, so cur_word holds
   // the pair from the start of its even pixel
   always_ff @(posedge clk) begin
      if (reset) begin
         next_word <= '0;
         cur_word <= '0;
      end else begin
         if (!raster.hcount[0]) begin
            next_word <= mem_rdata;
         end
         if (raster.hcount[0]) begin
            cur_word <= next_word;
         end
      end
   end

   // black around the camera image
   assign in_window = (raster.hcount < hcount_t'(win_width)) &&
                      (raster.vcount < vcount_t'(win_height));

   always_comb begin
      if (!in_window) begin
         cam_pixel = '0;
      end else if (raster.hcount[0]) begin
         cam_pixel = cur_word.lo_pixel;
      end else begin
         cam_pixel = cur_word.hi_pixel;
      end
   end

endmodule

`default_nettype wire

// ==== tb_frame_overlay.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the camera overlay display path: random frame
// contents, markers and button presses checked against a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_frame_overlay;
   import video_pkg::*;
   import frame_pkg::*;

   // small raster so a frame is quick to simulate
   localparam int h_active     = 64;
   localparam int h_sync_start = 68;
   localparam int h_sync_end   = 76;
   localparam int h_total      = 96;
   localparam int v_active     = 48;
   localparam int v_sync_start = 50;
   localparam int v_sync_end   = 52;
   localparam int v_total      = 56;
   localparam int win_width    = 40;
   localparam int win_height   = 30;
   localparam int marker_width = 4;
   localparam int pairs        = win_width / 2;
   localparam int frame_cycles = h_total * v_total;
   localparam int num_frames   = 24;

   logic         clk;
   logic         reset;
   frame_write_t cap_write;
   logic         mode_button;
   marker_pos_t  red_marker;
   marker_pos_t  green_marker;
   pixel24_t     vga_pixel;
   logic         vga_hsync;
   logic         vga_vsync;
   logic         vga_blank;

   // model state
   logic [15:0] lfsr_state;
   // shadow of the window words, index {line[4:0], pair[4:0]}
   frame_word_t shadow [0:1023];
   logic        known [0:1023];
   int          pos_h;
   int          pos_v;
   int          frame_num;
   int          fill_count;
   color_mode_t model_mode;
   logic        button_seen;
   logic [3:0]  mode_seen;
   // expected outputs for the position of the previous cycle
   pixel24_t    exp_pixel;
   logic        exp_hsync;
   logic        exp_vsync;
   logic        exp_blank;
   logic        exp_pixel_valid;

   frame_overlay_top #(
      .h_active     (h_active),
      .h_sync_start (h_sync_start),
      .h_sync_end   (h_sync_end),
      .h_total      (h_total),
      .v_active     (v_active),
      .v_sync_start (v_sync_start),
      .v_sync_end   (v_sync_end),
      .v_total      (v_total),
      .win_width    (win_width),
      .win_height   (win_height),
      .marker_width (marker_width)
   ) i_frame_overlay_top (
      .clk          (clk),
      .reset        (reset),
      .cap_write    (cap_write),
      .mode_button  (mode_button),
      .red_marker   (red_marker),
      .green_marker (green_marker),
      .vga_pixel    (vga_pixel),
      .vga_hsync    (vga_hsync),
      .vga_vsync    (vga_vsync),
      .vga_blank    (vga_blank)
   );

   // 100 ns period
   initial clk = 1'b0;
   always #50 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // random source and model helpers
   //////////////////////////////////////////////////////////////////////

   // 16 bit galois lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
   endtask

   function automatic logic [9:0] shadow_index(input int line, input int pair);
      return 10'(line * 32 + pair);
   endfunction

   // two zero bits below each 6 bit colour
   function automatic pixel24_t widen_pixel(input pixel18_t p);
      pixel24_t w;
      w.red = {p.red, 2'b00};
      w.green = {p.green, 2'b00};
      w.blue = {p.blue, 2'b00};
      return w;
   endfunction

   // vertical bar over the window height, horizontal bar over its width
   function automatic logic on_bars(input marker_pos_t m, input int h, input int v);
      int mx;
      int my;
      mx = int'(m.x);
      my = int'(m.y);
      return ((h >= mx) && (h < mx + marker_width) && (v < win_height)) ||
             ((v >= my) && (v < my + marker_width) && (h < win_width));
   endfunction

   // green, red, both, none, then green again
   function automatic color_mode_t next_mode(input color_mode_t m);
      case (m)
         mode_green: return mode_red;
         mode_red:   return mode_both;
         mode_both:  return mode_none;
         default:    return mode_green;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_reset_values();
      check_value("vga_pixel", 32'(vga_pixel), 32'd0);
      check_value("vga_hsync", 32'(vga_hsync), 32'd1);
      check_value("vga_vsync", 32'(vga_vsync), 32'd1);
      check_value("vga_blank", 32'(vga_blank), 32'd1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // per cycle model steps
   //////////////////////////////////////////////////////////////////////

   // the edge just passed saw the button level of the last cycle
   task automatic update_mode();
      if (mode_button && !button_seen) begin
         model_mode = next_mode(model_mode);
      end
      button_seen = mode_button;
   endtask

   task automatic advance_position();
      pos_h++;
      if (pos_h == h_total) begin
         pos_h = 0;
         pos_v++;
         if (pos_v == v_total) begin
            pos_v = 0;
            frame_num++;
         end
      end
   endtask

   task automatic drive_inputs();
      logic [31:0] r;
      int          wv;
      int          wp;
      // a write starts on an even count and is held over the odd one
      // last line is left free, it already reads the top of the frame
      if (pos_h % 2 == 0) begin
         if ((pos_v >= v_active) && (pos_v < v_total - 1)) begin
            // first pass fills the window in order, then random words
            if (fill_count < win_height * pairs) begin
               wv = fill_count / pairs;
               wp = fill_count % pairs;
               fill_count++;
            end else begin
               take_bits(5, r);
               wv = int'(r) % win_height;
               take_bits(5, r);
               wp = int'(r) % pairs;
            end
            take_bits(18, r);
            cap_write.word.hi_pixel = r[17:0];
            take_bits(18, r);
            cap_write.word.lo_pixel = r[17:0];
            cap_write.addr = 19'(wv * 512 + wp);
            cap_write.valid = 1'b1;
            shadow[shadow_index(wv, wp)] = cap_write.word;
            known[shadow_index(wv, wp)] = 1'b1;
         end else begin
            cap_write.valid = 1'b0;
         end
      end
      // markers and button move only on fully blanked lines
      if (pos_h == 0) begin
         if (pos_v == v_active) begin
            take_bits(7, r);
            red_marker.x = 11'(r);
            take_bits(6, r);
            red_marker.y = 10'(r);
            take_bits(7, r);
            green_marker.x = 11'(r);
            take_bits(6, r);
            green_marker.y = 10'(r);
            take_bits(1, r);
            mode_button = r[0];
         end else if (pos_v == v_active + 4) begin
            // held for four lines, one step at most
            mode_button = 1'b0;
         end
      end
   endtask

   task automatic predict_outputs();
      logic        show_green;
      logic        show_red;
      logic [9:0]  idx;
      frame_word_t w;
      show_green = on_bars(green_marker, pos_h, pos_v) &&
                   ((model_mode == mode_green) || (model_mode == mode_both));
      show_red = on_bars(red_marker, pos_h, pos_v) &&
                 ((model_mode == mode_red) || (model_mode == mode_both));
      exp_hsync = !((pos_h >= h_sync_start) && (pos_h < h_sync_end));
      exp_vsync = !((pos_v >= v_sync_start) && (pos_v < v_sync_end));
      exp_blank = (pos_h >= h_active) || (pos_v >= v_active);
      // first frame reads memory that is still being filled
      exp_pixel_valid = (frame_num >= 1);
      if (exp_blank) begin
         exp_pixel = '0;
      end else if (show_green) begin
         exp_pixel = green_marker_color;
      end else if (show_red) begin
         exp_pixel = red_marker_color;
      end else if ((pos_h < win_width) && (pos_v < win_height)) begin
         idx = shadow_index(pos_v, pos_h / 2);
         w = shadow[idx];
         exp_pixel_valid = exp_pixel_valid && known[idx];
         // even pixel in the upper half
         if (pos_h % 2 == 0) begin
            exp_pixel = widen_pixel(w.hi_pixel);
         end else begin
            exp_pixel = widen_pixel(w.lo_pixel);
         end
      end else begin
         exp_pixel = '0;
      end
   endtask

   task automatic check_outputs();
      check_value("vga_hsync", 32'(vga_hsync), 32'(exp_hsync));
      check_value("vga_vsync", 32'(vga_vsync), 32'(exp_vsync));
      check_value("vga_blank", 32'(vga_blank), 32'(exp_blank));
      if (exp_pixel_valid) begin
         check_value("vga_pixel", 32'(vga_pixel), 32'(exp_pixel));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      reset = 1'b1;
      cap_write = '0;
      mode_button = 1'b0;
      red_marker = '0;
      green_marker = '0;
      lfsr_state = 16'd43406;
      for (int i = 0; i < 1024; i++) begin
         known[i] = 1'b0;
      end
      model_mode = mode_green;
      button_seen = 1'b0;
      mode_seen = '0;
      pos_h = 0;
      pos_v = 0;
      frame_num = 0;
      fill_count = 0;
      // the last check falls in the cycle after release
      repeat (10) begin
         @(posedge clk);
         #1;
         check_reset_values();
      end
      reset = 1'b0;
      // raster shows 0,0 in this cycle
      drive_inputs();
      predict_outputs();
      for (int c = 0; c < num_frames * frame_cycles; c++) begin
         @(posedge clk);
         #1;
         update_mode();
         check_outputs();
         advance_position();
         if ((pos_h == 0) && (pos_v == 0)) begin
            mode_seen[model_mode] = 1'b1;
         end
         drive_inputs();
         predict_outputs();
      end
      if (mode_seen == 4'b1111) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("colour mode did not reach all four settings during the run");
         $display("TEST FAILED");
         $fatal(1, "mode coverage incomplete");
      end
   end

   // reset plus all frames, with a margin of one frame
   initial begin
      #((num_frames + 1) * frame_cycles * 100 + 50 * 100);
      $display("watchdog expired before the last frame was checked");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== video_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// video types: raster position and sync, pixel formats, marker
// positions, colour modes and the crosshair colours
//////////////////////////////////////////////////////////////////////

`default_nettype none

package video_pkg;

   // pixel count within a line, up to 2047
   typedef logic [10:0] hcount_t;
   // line count within a frame
   typedef logic [9:0] vcount_t;

   // one raster position with its sync and blank levels
   typedef struct packed {
      hcount_t hcount;
      vcount_t vcount;
      // active low
      logic    hsync;
      // active low
      logic    vsync;
      // active high, outside the visible area
      logic    blank;
   } raster_t;

   // stored camera pixel, 6 bits per colour
   typedef struct packed {
      logic [5:0] red;
      logic [5:0] green;
      logic [5:0] blue;
   } pixel18_t;

   // dac pixel, 8 bits per colour
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } pixel24_t;

   // crosshair centre in raster coordinates
   typedef struct packed {
      hcount_t x;
      vcount_t y;
   } marker_pos_t;

   // which crosshairs are drawn, stepped in this order by the button
   typedef enum logic [1:0] {
      mode_green = 2'd0,
      mode_red   = 2'd1,
      mode_both  = 2'd2,
      mode_none  = 2'd3
   } color_mode_t;

   // slightly desaturated so the bars stand out on a camera image
   localparam pixel24_t red_marker_color = 24'hFF_30_30;
   localparam pixel24_t green_marker_color = 24'h30_FF_30;

endpackage

`default_nettype wire

// ==== video_timing.sv ====
//////////////////////////////////////////////////////////////////////
// raster generator: pixel and line counters with sync and blank
// levels decoded from the current position
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module video_timing #(
   parameter int h_active     = 1024,
   parameter int h_sync_start = 1048,
   parameter int h_sync_end   = 1184,
   parameter int h_total      = 1344,
   parameter int v_active     = 768,
   parameter int v_sync_start = 777,
   parameter int v_sync_end   = 783,
   parameter int v_total      = 806
) (
   input  logic               clk,
   input  logic               reset,
   output video_pkg::raster_t raster
);
   import video_pkg::*;

   hcount_t hcount;
   vcount_t vcount;
   logic    line_end;
   logic    frame_end;

   assign line_end = (hcount == hcount_t'(h_total - 1));
   assign frame_end = (vcount == vcount_t'(v_total - 1));

   // one pixel per clock, line count moves on the line wrap
   always_ff @(posedge clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
      end else if (line_end) begin
         hcount <= '0;
         if (frame_end) begin
            vcount <= '0;
         end else begin
            vcount <= vcount + 1'b1;
         end
      end else begin
         hcount <= hcount + 1'b1;
      end
   end

   // flags follow the count in the same cycle
   always_comb begin
      raster.hcount = hcount;
      raster.vcount = vcount;
      raster.hsync = !((hcount >= hcount_t'(h_sync_start)) &&
                       (hcount < hcount_t'(h_sync_end)));
      raster.vsync = !((vcount >= vcount_t'(v_sync_start)) &&
                       (vcount < vcount_t'(v_sync_end)));
      raster.blank = (hcount >= hcount_t'(h_active)) ||
                     (vcount >= vcount_t'(v_active));
   end

endmodule

`default_nettype wire
